// ==== list.f ====
src/agcPkg.sv
src/agcLoopRegs.sv
src/agcMagEstimator.sv
src/agcLoopFilter.sv
src/agcGainScaler.sv
src/agcLoop.sv
tb/agcLoopTb.sv

// ==== src/agcGainScaler.sv ====
// Output stage of the AGC: scales each sample by the integrator gain field
// Q4.12 gain, result saturated to 16 bits and registered with outValid

`timescale 1ns/1ps

module agcGainScaler import agcPkg::*; (
    input  logic   busClk,
    input  logic   rstN,
    input  sampleT sampleI,
    input  sampleT sampleQ,
    input  logic   sampleValid,
    input  accT    integrator,
    output sampleT outI,
    output sampleT outQ,
    output logic   outValid
);

    logic [15:0] gain;

    function automatic sampleT scaleSat(input sampleT s, input logic [15:0] g);
        logic signed [32:0] prod;
        logic signed [32:0] shifted;
        prod    = s * $signed({1'b0, g});
        shifted = prod >>> gainFracBits;
        if (shifted > 33'sd32767)
            return 16'sh7fff;
        else if (shifted < -33'sd32768)
            return 16'sh8000;
        return shifted[15:0];
    endfunction

    assign gain = integrator[gainLsb +: 16];    // Unsigned gain field

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            outI     <= '0;
            outQ     <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= sampleValid;
            if (sampleValid) begin
                outI <= scaleSat(sampleI, gain);
                outQ <= scaleSat(sampleQ, gain);
            end
        end
    end

endmodule

// ==== src/agcLoop.sv ====
// Top level of the AGC loop
// Bus registers, magnitude estimator, loop filter and gain scaler on busClk

`timescale 1ns/1ps

module agcLoop import agcPkg::*; (
    input  logic    busClk,
    input  logic    rstN,
    input  busAddrT addr,
    input  busDataT dataIn,
    output busDataT dataOut,
    input  logic    cs,
    input  logic    wr0,
    input  logic    wr1,
    input  logic    wr2,
    input  logic    wr3,
    input  sampleT  sampleI,
    input  sampleT  sampleQ,
    input  logic    sampleValid,
    output sampleT  outI,
    output sampleT  outQ,
    output logic    outValid
);

    levelT agcSetpoint;
    logic  invertError;
    logic  zeroError;
    shiftT posErrorGain;
    shiftT negErrorGain;
    accT   upperLimit;
    accT   lowerLimit;
    accT   integrator;
    levelT level;
    logic  magValid;

    agcLoopRegs regs (
        .busClk(busClk), .rstN(rstN),
        .addr(addr), .dataIn(dataIn), .dataOut(dataOut), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .agcSetpoint(agcSetpoint), .invertError(invertError), .zeroError(zeroError),
        .posErrorGain(posErrorGain), .negErrorGain(negErrorGain),
        .upperLimit(upperLimit), .lowerLimit(lowerLimit),
        .integrator(integrator)
    );

    agcMagEstimator magEst (
        .busClk(busClk), .rstN(rstN),
        .sampleI(sampleI), .sampleQ(sampleQ), .sampleValid(sampleValid),
        .level(level), .magValid(magValid)
    );

    agcLoopFilter loopFilter (
        .busClk(busClk), .rstN(rstN),
        .level(level), .magValid(magValid),
        .agcSetpoint(agcSetpoint), .invertError(invertError), .zeroError(zeroError),
        .posErrorGain(posErrorGain), .negErrorGain(negErrorGain),
        .upperLimit(upperLimit), .lowerLimit(lowerLimit),
        .integrator(integrator)
    );

    agcGainScaler gainScaler (
        .busClk(busClk), .rstN(rstN),
        .sampleI(sampleI), .sampleQ(sampleQ), .sampleValid(sampleValid),
        .integrator(integrator),
        .outI(outI), .outQ(outQ), .outValid(outValid)
    );

endmodule

// ==== src/agcLoopFilter.sv ====
// Loop filter of the AGC: error against setpoint, sign-dependent shift gain
// and an integrator clamped between the programmed limits
// The clamped integrator reaches the port two cycles after magValid

`timescale 1ns/1ps

module agcLoopFilter import agcPkg::*; (
    input  logic  busClk,
    input  logic  rstN,
    input  levelT level,
    input  logic  magValid,
    input  levelT agcSetpoint,
    input  logic  invertError,
    input  logic  zeroError,
    input  shiftT posErrorGain,
    input  shiftT negErrorGain,
    input  accT   upperLimit,
    input  accT   lowerLimit,
    output accT   integrator
);

    localparam int errW = 9;
    localparam int sumW = $bits(accT) + errW;   // Holds any shifted error plus integrator

    filterStateT            state;
    logic signed [errW-1:0] errRaw;
    logic signed [errW-1:0] errReg;
    shiftT                  errGain;
    logic signed [sumW-1:0] errShifted;
    logic signed [sumW-1:0] integWide;
    logic signed [sumW-1:0] sumWide;

    function automatic accT limitAcc(
        input logic signed [sumW-1:0] v,
        input accT                    lo,
        input accT                    hi
    );
        if (v > hi)
            return hi;
        else if (v < lo)
            return lo;
        return v[31:0];
    endfunction

    // ======================================================================
    // Error and gain
    // ======================================================================
    always_comb begin
        errRaw = $signed({1'b0, agcSetpoint}) - $signed({1'b0, level});
        if (zeroError)
            errRaw = '0;
        else if (invertError)
            errRaw = -errRaw;
    end

    assign errGain    = errReg[errW-1] ? negErrorGain : posErrorGain;
    assign errShifted = $signed({{(sumW-errW){errReg[errW-1]}}, errReg}) <<< errGain;
    assign integWide  = $signed({{(sumW-32){integrator[31]}}, integrator});
    assign sumWide    = integWide + errShifted;

    always_ff @(posedge busClk) begin
        if (state == idle && magValid)
            errReg <= errRaw;
    end

    // ======================================================================
    // Integrator FSM
    // ======================================================================
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            state      <= idle;
            integrator <= '0;
        end else begin
            case (state)
                idle: begin
                    if (magValid)
                        state <= accumulate;
                end
                accumulate: begin
                    integrator <= limitAcc(sumWide, lowerLimit, upperLimit);
                    state      <= clamp;
                end
                clamp: begin
                    // Limits may have moved on the bus while summing
                    integrator <= limitAcc(integWide, lowerLimit, upperLimit);
                    state      <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // Samples come no closer than four cycles apart
    magSpacingA: assert property (@(posedge busClk) disable iff (!rstN)
        magValid |-> state == idle)
        else $error("magValid arrived while filter busy");

    integratorRangeA: assert property (@(posedge busClk) disable iff (!rstN)
        (state == clamp && lowerLimit <= upperLimit) |=>
            (integrator >= $past(lowerLimit) && integrator <= $past(upperLimit)))
        else $error("integrator outside programmed limits");

endmodule

// ==== src/agcLoopRegs.sv ====
// Control registers of the AGC loop on the 32-bit processor bus
// Byte-strobe writes on busClk, readback is combinational while cs is high

`timescale 1ns/1ps

module agcLoopRegs import agcPkg::*; (
    input  logic    busClk,
    input  logic    rstN,
    input  busAddrT addr,
    input  busDataT dataIn,
    output busDataT dataOut,
    input  logic    cs,
    input  logic    wr0,
    input  logic    wr1,
    input  logic    wr2,
    input  logic    wr3,
    output levelT   agcSetpoint,
    output logic    invertError,
    output logic    zeroError,
    output shiftT   posErrorGain,
    output shiftT   negErrorGain,
    output accT     upperLimit,
    output accT     lowerLimit,
    input  accT     integrator
);

    // ======================================================================
    // Write side
    // ======================================================================
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            agcSetpoint  <= '0;
            invertError  <= 1'b0;
            zeroError    <= 1'b0;
            posErrorGain <= '0;
            negErrorGain <= '0;
            upperLimit   <= '0;
            lowerLimit   <= '0;
        end else begin
            if (cs && wr0) begin
                case (addr)
                    alfControl: begin
                        zeroError   <= dataIn[0];
                        invertError <= dataIn[1];
                    end
                    alfSetpoint:   agcSetpoint      <= dataIn[7:0];
                    alfGains:      posErrorGain     <= dataIn[4:0];
                    alfUpperLimit: upperLimit[7:0]  <= dataIn[7:0];
                    alfLowerLimit: lowerLimit[7:0]  <= dataIn[7:0];
                    default: ;
                endcase
            end

            if (cs && wr1) begin
                case (addr)
                    alfUpperLimit: upperLimit[15:8] <= dataIn[15:8];
                    alfLowerLimit: lowerLimit[15:8] <= dataIn[15:8];
                    default: ;
                endcase
            end

            if (cs && wr2) begin
                case (addr)
                    alfGains:      negErrorGain      <= dataIn[20:16];
                    alfUpperLimit: upperLimit[23:16] <= dataIn[23:16];
                    alfLowerLimit: lowerLimit[23:16] <= dataIn[23:16];
                    default: ;
                endcase
            end

            if (cs && wr3) begin
                case (addr)
                    alfUpperLimit: upperLimit[31:24] <= dataIn[31:24];
                    alfLowerLimit: lowerLimit[31:24] <= dataIn[31:24];
                    default: ;
                endcase
            end
        end
    end

    // ======================================================================
    // Readback
    // ======================================================================
    always_comb begin
        dataOut = '0;                       // Idle bus and holes read zero
        if (cs) begin
            case (addr)
                alfControl:    dataOut = {30'b0, invertError, zeroError};
                alfSetpoint:   dataOut = {24'b0, agcSetpoint};
                alfGains:      dataOut = {11'b0, negErrorGain, 11'b0, posErrorGain};
                alfUpperLimit: dataOut = upperLimit;
                alfLowerLimit: dataOut = lowerLimit;
                alfIntegrator: dataOut = integrator;    // Live loop state
                default:       dataOut = '0;
            endcase
        end
    end

    // Software must never try to load the integrator
    integratorWriteA: assert property (@(posedge busClk) disable iff (!rstN)
        !(cs && (wr0 || wr1 || wr2 || wr3) && addr == alfIntegrator))
        else $error("write strobe to read-only integrator address");

endmodule

// ==== src/agcMagEstimator.sv ====
// Magnitude estimate of each I/Q sample for the AGC loop
// max(|I|,|Q|) + min/2, scaled and saturated to an 8-bit level one cycle later

`timescale 1ns/1ps

module agcMagEstimator import agcPkg::*; (
    input  logic   busClk,
    input  logic   rstN,
    input  sampleT sampleI,
    input  sampleT sampleQ,
    input  logic   sampleValid,
    output levelT  level,
    output logic   magValid
);

    logic [14:0] absI;
    logic [14:0] absQ;
    logic [14:0] bigger;
    logic [14:0] smaller;
    logic [15:0] magSum;
    logic [15:0] scaled;
    levelT       levelNext;

    // Absolute value, with -32768 pinned to 32767
    function automatic logic [14:0] absSat(input sampleT s);
        logic [15:0] mag;
        mag = s[15] ? 16'(-s) : 16'(s);
        return mag[15] ? 15'h7fff : mag[14:0];
    endfunction

    // ======================================================================
    // Estimate
    // ======================================================================
    always_comb begin
        absI = absSat(sampleI);
        absQ = absSat(sampleQ);

        if (absI >= absQ) begin
            bigger  = absI;
            smaller = absQ;
        end else begin
            bigger  = absQ;
            smaller = absI;
        end

        magSum = {1'b0, bigger} + {2'b0, smaller[14:1]};   // Cannot overflow
        scaled = magSum >> magShift;

        if (|scaled[15:8])
            levelNext = 8'hff;              // Saturate
        else
            levelNext = scaled[7:0];
    end

    // ======================================================================
    // Output registers
    // ======================================================================
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN)
            magValid <= 1'b0;
        else
            magValid <= sampleValid;
    end

    always_ff @(posedge busClk) begin
        if (sampleValid)
            level <= levelNext;
    end

endmodule

// ==== src/agcPkg.sv ====
// Shared widths, register map and loop constants for the AGC loop
// Every RTL block imports what it needs from here

package agcPkg;

    // ======================================================================
    // Widths
    // ======================================================================
    typedef logic [12:0]        busAddrT;   // Byte address
    typedef logic [31:0]        busDataT;
    typedef logic signed [15:0] sampleT;    // One I or Q sample
    typedef logic [7:0]         levelT;     // Magnitude and setpoint
    typedef logic [4:0]         shiftT;     // Error gain as left shift
    typedef logic signed [31:0] accT;       // Integrator and limits

    // ======================================================================
    // Register map
    // ======================================================================
    localparam busAddrT alfControl    = 13'h000;    // 0 zeroError, 1 invertError
    localparam busAddrT alfSetpoint   = 13'h004;
    localparam busAddrT alfGains      = 13'h008;    // Pos in 4:0, neg in 20:16
    localparam busAddrT alfUpperLimit = 13'h00C;
    localparam busAddrT alfLowerLimit = 13'h010;
    localparam busAddrT alfIntegrator = 13'h014;    // Read only

    // ======================================================================
    // Loop constants
    // ======================================================================
    localparam int magShift     = 7;    // Magnitude sum down to level
    localparam int gainLsb      = 8;    // Gain field is integrator 23:8
    localparam int gainFracBits = 12;   // 4096 is unity gain

    typedef enum logic [1:0] {
        idle,
        accumulate,
        clamp
    } filterStateT;

endpackage

// ==== tb/agcLoopTb.sv ====
// Table-driven testbench for the AGC loop
// Runs bus writes, bus reads and LFSR sample bursts against a reference model
// of the magnitude estimate, loop filter and gain scaler

`timescale 1ns/1ps

module agcLoopTb import agcPkg::*; ();

    localparam int resetCycles = 16;
    localparam int stepCycles  = 64;        // Watchdog budget per table step

    typedef enum int {opWrite, opRead, opBurst} opT;

    logic    busClk;
    logic    rstN;
    busAddrT addr;
    busDataT dataIn;
    busDataT dataOut;
    logic    cs;
    logic    wr0;
    logic    wr1;
    logic    wr2;
    logic    wr3;
    sampleT  sampleI;
    sampleT  sampleQ;
    logic    sampleValid;
    sampleT  outI;
    sampleT  outQ;
    logic    outValid;

    opT         opQ[$];                     // Stimulus table columns
    int         argQ[$];
    busDataT    dataQ[$];
    logic [3:0] strbQ[$];
    busDataT    expQ[$];

    busDataT     regShadow[5];              // Model of the register file
    accT         integM;                    // Model integrator
    logic [31:0] lfsr;
    int          stepErrors;
    int          passed;
    int          failed;

    agcLoop uut (
        .busClk(busClk), .rstN(rstN),
        .addr(addr), .dataIn(dataIn), .dataOut(dataOut), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .sampleI(sampleI), .sampleQ(sampleQ), .sampleValid(sampleValid),
        .outI(outI), .outQ(outQ), .outValid(outValid)
    );

    initial begin
        busClk = 1'b0;
        forever #20 busClk = ~busClk;
    end

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic busDataT implMask(input busAddrT a);
        case (a)
            alfControl:    return 32'h0000_0003;
            alfSetpoint:   return 32'h0000_00ff;
            alfGains:      return 32'h001f_001f;
            alfUpperLimit: return 32'hffff_ffff;
            alfLowerLimit: return 32'hffff_ffff;
            default:       return 32'h0;
        endcase
    endfunction

    function automatic int expLevel(input int i, input int q);
        int ai;
        int aq;
        int m;
        ai = (i < 0) ? -i : i;
        aq = (q < 0) ? -q : q;
        if (ai > 32767)
            ai = 32767;
        if (aq > 32767)
            aq = 32767;
        m = (ai >= aq) ? ai + aq / 2 : aq + ai / 2;
        m = m >> magShift;
        return (m > 255) ? 255 : m;
    endfunction

    function automatic sampleT expScale(input int s, input int g);
        longint p;
        p = longint'(s) * longint'(g);
        p = p >>> gainFracBits;
        if (p > 32767)
            return 16'sh7fff;
        if (p < -32768)
            return 16'sh8000;
        return p[15:0];
    endfunction

    task automatic stepModel(input int i, input int q);
        int     err;
        int     sh;
        longint sum;
        longint hi;
        longint lo;
        err = int'(regShadow[1][7:0]) - expLevel(i, q);
        if (regShadow[0][0])
            err = 0;                        // zeroError wins over invert
        else if (regShadow[0][1])
            err = -err;
        sh  = (err < 0) ? regShadow[2][20:16] : regShadow[2][4:0];
        sum = longint'(integM) + (longint'(err) <<< sh);
        hi  = $signed(regShadow[3]);
        lo  = $signed(regShadow[4]);
        if (sum > hi)
            integM = hi;
        else if (sum < lo)
            integM = lo;
        else
            integM = sum[31:0];
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        stepErrors++;
    endtask

    // ======================================================================
    // Bus and sample drivers
    // ======================================================================
    task automatic busWrite(input busAddrT a, input busDataT d, input logic [3:0] s);
        busDataT mask;
        @(negedge busClk);
        addr   = a;
        dataIn = d;
        cs     = 1'b1;
        {wr3, wr2, wr1, wr0} = s;
        @(negedge busClk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0;
        mask = implMask(a) & {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        regShadow[a[4:2]] = (regShadow[a[4:2]] & ~mask) | (d & mask);
    endtask

    task automatic busRead(input busAddrT a, output busDataT d);
        @(negedge busClk);
        addr = a;
        cs   = 1'b1;
        @(negedge busClk);
        d  = dataOut;                       // Held a full cycle, well settled
        cs = 1'b0;
    endtask

    // Four cycles per sample, integrator read back after each one
    task automatic runBurst(input int n);
        sampleT  raw;
        int      sh;
        int      si;
        int      sq;
        sampleT  expI;
        sampleT  expQ;
        busDataT rd;
        for (int k = 0; k < n; k++) begin
            sh  = takeBits(3);
            raw = takeBits(16);
            si  = raw >>> sh;
            raw = takeBits(16);
            sq  = raw >>> sh;
            @(negedge busClk);
            sampleI     = si;
            sampleQ     = sq;
            sampleValid = 1'b1;
            expI = expScale(si, integM[gainLsb +: 16]);    // Gain before this sample
            expQ = expScale(sq, integM[gainLsb +: 16]);
            stepModel(si, sq);
            @(negedge busClk);
            sampleValid = 1'b0;
            if (outValid !== 1'b1)
                reportMismatch("outValid", outValid, 1);
            if (outI !== expI)
                reportMismatch("outI", outI, expI);
            if (outQ !== expQ)
                reportMismatch("outQ", outQ, expQ);
            busRead(alfIntegrator, rd);
            if (outValid !== 1'b0)
                reportMismatch("outValid", outValid, 0);
            if (rd !== integM)
                reportMismatch("integrator", rd, integM);
            if ($signed(rd) > $signed(regShadow[3]) || $signed(rd) < $signed(regShadow[4])) begin
                $display("Integrator 0x%h passed a programmed limit at %0t ns", rd, $time);
                stepErrors++;
            end
        end
    endtask

    // ======================================================================
    // Stimulus table
    // ======================================================================
    task automatic addStep(input opT op, input int arg, input busDataT d,
                           input logic [3:0] s, input busDataT e);
        opQ.push_back(op);
        argQ.push_back(arg);
        dataQ.push_back(d);
        strbQ.push_back(s);
        expQ.push_back(e);
    endtask

    task automatic loadTable();
        addStep(opWrite, alfControl,    32'hffff_ffff, 4'b0001, 32'h0);
        addStep(opRead,  alfControl,    32'h0,         4'b0000, 32'h0000_0003);
        addStep(opWrite, alfControl,    32'h0,         4'b1110, 32'h0);
        addStep(opRead,  alfControl,    32'h0,         4'b0000, 32'h0000_0003);
        addStep(opWrite, alfSetpoint,   32'hffff_ff80, 4'b0001, 32'h0);
        addStep(opRead,  alfSetpoint,   32'h0,         4'b0000, 32'h0000_0080);
        addStep(opWrite, alfGains,      32'hffff_ffff, 4'b0100, 32'h0);
        addStep(opRead,  alfGains,      32'h0,         4'b0000, 32'h001f_0000);
        addStep(opWrite, alfGains,      32'hffff_ffe3, 4'b0001, 32'h0);
        addStep(opRead,  alfGains,      32'h0,         4'b0000, 32'h001f_0003);
        addStep(opWrite, alfUpperLimit, 32'h1122_3344, 4'b1010, 32'h0);
        addStep(opRead,  alfUpperLimit, 32'h0,         4'b0000, 32'h1100_3300);
        addStep(opWrite, alfUpperLimit, 32'h5566_7788, 4'b0101, 32'h0);
        addStep(opRead,  alfUpperLimit, 32'h0,         4'b0000, 32'h1166_3388);
        addStep(opWrite, alfLowerLimit, 32'haabb_ccdd, 4'b1111, 32'h0);
        addStep(opRead,  alfLowerLimit, 32'h0,         4'b0000, 32'haabb_ccdd);
        addStep(opRead,  13'h018,       32'h0,         4'b0000, 32'h0);
        // Plain integration with wide limits
        addStep(opWrite, alfControl,    32'h0,         4'b0001, 32'h0);
        addStep(opWrite, alfGains,      32'h0,         4'b0101, 32'h0);
        addStep(opWrite, alfUpperLimit, 32'h7fff_ffff, 4'b1111, 32'h0);
        addStep(opWrite, alfLowerLimit, 32'h8000_0000, 4'b1111, 32'h0);
        addStep(opWrite, alfSetpoint,   32'h0000_0040, 4'b0001, 32'h0);
        addStep(opBurst, 6,             32'h0,         4'b0000, 32'h0);
        // Zero, invert and sign-dependent gains
        addStep(opWrite, alfControl,    32'h0000_0001, 4'b0001, 32'h0);
        addStep(opBurst, 4,             32'h0,         4'b0000, 32'h0);
        addStep(opWrite, alfControl,    32'h0000_0002, 4'b0001, 32'h0);
        addStep(opBurst, 4,             32'h0,         4'b0000, 32'h0);
        addStep(opWrite, alfControl,    32'h0,         4'b0001, 32'h0);
        addStep(opWrite, alfGains,      32'h0005_0002, 4'b0101, 32'h0);
        addStep(opBurst, 6,             32'h0,         4'b0000, 32'h0);
        // Drive into both limits
        addStep(opWrite, alfGains,      32'h001f_001f, 4'b0101, 32'h0);
        addStep(opWrite, alfUpperLimit, 32'h0020_0000, 4'b1111, 32'h0);
        addStep(opWrite, alfLowerLimit, 32'hffe0_0000, 4'b1111, 32'h0);
        addStep(opWrite, alfSetpoint,   32'h0000_00ff, 4'b0001, 32'h0);
        addStep(opBurst, 3,             32'h0,         4'b0000, 32'h0);
        addStep(opRead,  alfIntegrator, 32'h0,         4'b0000, 32'h0020_0000);
        addStep(opWrite, alfSetpoint,   32'h0,         4'b0001, 32'h0);
        addStep(opBurst, 3,             32'h0,         4'b0000, 32'h0);
        addStep(opRead,  alfIntegrator, 32'h0,         4'b0000, 32'hffe0_0000);
        // Pinned gains: unity, half, then full scale
        addStep(opWrite, alfControl,    32'h0000_0001, 4'b0001, 32'h0);
        addStep(opWrite, alfUpperLimit, 32'h0010_0000, 4'b1111, 32'h0);
        addStep(opWrite, alfLowerLimit, 32'h0010_0000, 4'b1111, 32'h0);
        addStep(opBurst, 5,             32'h0,         4'b0000, 32'h0);
        addStep(opRead,  alfIntegrator, 32'h0,         4'b0000, 32'h0010_0000);
        addStep(opWrite, alfLowerLimit, 32'h0008_0000, 4'b1111, 32'h0);
        addStep(opWrite, alfUpperLimit, 32'h0008_0000, 4'b1111, 32'h0);
        addStep(opBurst, 4,             32'h0,         4'b0000, 32'h0);
        addStep(opRead,  alfIntegrator, 32'h0,         4'b0000, 32'h0008_0000);
        addStep(opWrite, alfUpperLimit, 32'h00ff_ff00, 4'b1111, 32'h0);
        addStep(opWrite, alfLowerLimit, 32'h00ff_ff00, 4'b1111, 32'h0);
        addStep(opBurst, 4,             32'h0,         4'b0000, 32'h0);
        addStep(opRead,  alfIntegrator, 32'h0,         4'b0000, 32'h00ff_ff00);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        busDataT rd;
        rstN        = 1'b0;
        addr        = '0;
        dataIn      = '0;
        cs          = 1'b0;
        wr0         = 1'b0;
        wr1         = 1'b0;
        wr2         = 1'b0;
        wr3         = 1'b0;
        sampleI     = '0;
        sampleQ     = '0;
        sampleValid = 1'b0;
        lfsr        = 32'hcec1;
        integM      = '0;
        passed      = 0;
        failed      = 0;
        foreach (regShadow[r])
            regShadow[r] = '0;
        loadTable();
        repeat (resetCycles) @(posedge busClk);
        @(negedge busClk);
        rstN = 1'b1;
        for (int idx = 0; idx < opQ.size(); idx++) begin
            stepErrors = 0;
            case (opQ[idx])
                opWrite: busWrite(argQ[idx], dataQ[idx], strbQ[idx]);
                opRead: begin
                    busRead(argQ[idx], rd);
                    if (rd !== expQ[idx])
                        reportMismatch("dataOut", rd, expQ[idx]);
                end
                default: runBurst(argQ[idx]);
            endcase
            if (stepErrors == 0)
                passed++;
            else
                failed++;
            $display("[%0t ns] step %0d %s 0x%0h: %s", $time, idx,
                     (opQ[idx] == opWrite) ? "write" : (opQ[idx] == opRead) ? "read" : "burst",
                     argQ[idx], (stepErrors == 0) ? "ok" : "failed");
        end
        $display("Steps run %0d, passed %0d, failed %0d", opQ.size(), passed, failed);
        if (failed == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        #1;                                 // Table is loaded at time zero
        repeat (opQ.size() * stepCycles + resetCycles) @(posedge busClk);
        $display("Timeout: table did not finish within %0d cycles",
                 opQ.size() * stepCycles + resetCycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule
